// ==== source/ifetch_pkg.sv ====
package ifetch_pkg;

  // CRMD layout
  // bits 1..0 plv, 2 ie, 3 da, 4 pg, 6..5 datf, 8..7 datm
  typedef struct packed {
    logic [22:0] rsvd;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    logic [1:0]  plv;
  } csr_crmd_t;

  // DMW layout
  // bit 0 plv0, 3 plv3, 5..4 mat, 27..25 pseg, 31..29 vseg
  typedef struct packed {
    logic [2:0]  vseg;
    logic        rsvd_28;
    logic [2:0]  pseg;
    logic [18:0] rsvd_24_6;
    logic [1:0]  mat;
    logic        plv3;
    logic [1:0]  rsvd_2_1;
    logic        plv0;
  } csr_dmw_t;

  // one csr word, read as crmd or dmw fields by register index
  typedef union packed {
    csr_crmd_t crmd;
    csr_dmw_t  dmw;
  } csr_word_u;

  // register indices on the csr bus address
  localparam logic [1:0] CSR_CRMD = 2'd0;
  localparam logic [1:0] CSR_DMW0 = 2'd1;
  localparam logic [1:0] CSR_DMW1 = 2'd2;

  // da set, plv 0, datf 1 (coherent cached)
  localparam logic [31:0] CRMD_RESET = 32'h0000_0028;

  // memory access type meaning cached
  localparam logic [1:0] MAT_CC = 2'd1;

endpackage

// ==== source/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  csr_cyc_i,
  input  logic                  csr_stb_i,
  input  logic                  csr_we_i,
  input  logic [1:0]            csr_adr_i,
  input  logic [31:0]           csr_dat_i,
  output logic [31:0]           csr_dat_o,
  output logic                  csr_ack_o,
  output logic                  csr_wr_o,
  output ifetch_pkg::csr_word_u csr_crmd_o,
  output ifetch_pkg::csr_word_u csr_dmw0_o,
  output ifetch_pkg::csr_word_u csr_dmw1_o
);

  logic                  req;
  logic                  wr_valid;
  ifetch_pkg::csr_word_u wr_word;
  ifetch_pkg::csr_word_u crmd_wr;
  ifetch_pkg::csr_word_u dmw_wr;

  // new cycle only when ack is not already out
  assign req      = csr_cyc_i && csr_stb_i && !csr_ack_o;
  assign wr_valid = req && csr_we_i && (csr_adr_i != 2'd3);

  // keep only defined fields of the incoming word
  always_comb begin
    wr_word = csr_dat_i;
    crmd_wr = '0;
    crmd_wr.crmd.plv  = wr_word.crmd.plv;
    crmd_wr.crmd.ie   = wr_word.crmd.ie;
    crmd_wr.crmd.da   = wr_word.crmd.da;
    crmd_wr.crmd.pg   = wr_word.crmd.pg;
    crmd_wr.crmd.datf = wr_word.crmd.datf;
    crmd_wr.crmd.datm = wr_word.crmd.datm;
    dmw_wr = '0;
    dmw_wr.dmw.plv0 = wr_word.dmw.plv0;
    dmw_wr.dmw.plv3 = wr_word.dmw.plv3;
    dmw_wr.dmw.mat  = wr_word.dmw.mat;
    dmw_wr.dmw.pseg = wr_word.dmw.pseg;
    dmw_wr.dmw.vseg = wr_word.dmw.vseg;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      csr_ack_o  <= 1'b0;
      csr_wr_o   <= 1'b0;
      csr_crmd_o <= ifetch_pkg::CRMD_RESET;
      csr_dmw0_o <= '0;
      csr_dmw1_o <= '0;
    end else begin
      csr_ack_o <= req;
      csr_wr_o  <= wr_valid;
      if (wr_valid) begin
        case (csr_adr_i)
          ifetch_pkg::CSR_CRMD: csr_crmd_o <= crmd_wr;
          ifetch_pkg::CSR_DMW0: csr_dmw0_o <= dmw_wr;
          ifetch_pkg::CSR_DMW1: csr_dmw1_o <= dmw_wr;
          default: ;
        endcase
      end
    end
  end

  // read data sampled with the request and held through ack
  always_ff @(posedge clk) begin
    if (req) begin
      case (csr_adr_i)
        ifetch_pkg::CSR_CRMD: csr_dat_o <= csr_crmd_o;
        ifetch_pkg::CSR_DMW0: csr_dat_o <= csr_dmw0_o;
        ifetch_pkg::CSR_DMW1: csr_dat_o <= csr_dmw1_o;
        default:              csr_dat_o <= '0;
      endcase
    end
  end

  // ack lasts a single cycle
  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    csr_ack_o |=> !csr_ack_o);

endmodule

// ==== source/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc #(
  parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        pc_advance_i,
  input  logic        pc_load_i,
  input  logic [31:0] pc_load_val_i,
  output logic [31:0] pc_o
);

  logic [31:0] pc_q;

  // load wins over sequential advance
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else if (pc_load_i) begin
      pc_q <= pc_load_val_i;
    end else if (pc_advance_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_o = pc_q;

  // controller folds an advance into the load value
  no_advance_with_load: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(pc_advance_i && pc_load_i));

endmodule

// ==== source/iaddr_trans.sv ====
`timescale 1ns/1ps

module iaddr_trans (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  trans_en_i,
  input  logic [31:0]           vaddr_i,
  input  ifetch_pkg::csr_word_u csr_crmd_i,
  input  ifetch_pkg::csr_word_u csr_dmw0_i,
  input  ifetch_pkg::csr_word_u csr_dmw1_i,
  output logic [31:0]           paddr_o,
  output logic                  uncached_o,
  output logic                  adef_o
);

  logic       da_mode;
  logic       plv0;
  logic       plv3;
  logic       dmw0_hit;
  logic       dmw1_hit;
  logic [2:0] seg_d;
  logic       uncached_d;
  logic       adef_d;

  // privilege level and window decode
  always_comb begin
    da_mode = csr_crmd_i.crmd.da;
    plv0    = csr_crmd_i.crmd.plv == 2'd0;
    plv3    = csr_crmd_i.crmd.plv == 2'd3;
    dmw0_hit = ((csr_dmw0_i.dmw.plv0 && plv0) || (csr_dmw0_i.dmw.plv3 && plv3)) &&
               (csr_dmw0_i.dmw.vseg == vaddr_i[31:29]);
    dmw1_hit = ((csr_dmw1_i.dmw.plv0 && plv0) || (csr_dmw1_i.dmw.plv3 && plv3)) &&
               (csr_dmw1_i.dmw.vseg == vaddr_i[31:29]);
  end

  // segment and attribute, dmw0 takes precedence
  always_comb begin
    if (da_mode) begin
      seg_d      = vaddr_i[31:29];
      uncached_d = csr_crmd_i.crmd.datf != ifetch_pkg::MAT_CC;
    end else if (dmw0_hit) begin
      seg_d      = csr_dmw0_i.dmw.pseg;
      uncached_d = csr_dmw0_i.dmw.mat != ifetch_pkg::MAT_CC;
    end else begin
      seg_d      = csr_dmw1_i.dmw.pseg;
      uncached_d = csr_dmw1_i.dmw.mat != ifetch_pkg::MAT_CC;
    end
    adef_d = (|vaddr_i[1:0]) || (!da_mode && !dmw0_hit && !dmw1_hit);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      uncached_o <= 1'b0;
      adef_o     <= 1'b0;
    end else if (trans_en_i) begin
      uncached_o <= uncached_d;
      adef_o     <= adef_d;
    end
  end

  always_ff @(posedge clk) begin
    if (trans_en_i) begin
      paddr_o <= {seg_d, vaddr_i[28:0]};
    end
  end

endmodule

// ==== source/ifetch_ctrl.sv ====
`timescale 1ns/1ps

module ifetch_ctrl (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [31:0] pc_i,
  output logic        pc_advance_o,
  output logic        pc_load_o,
  output logic [31:0] pc_load_val_o,
  output logic        trans_en_o,
  input  logic [31:0] paddr_i,
  input  logic        uncached_i,
  input  logic        adef_i,
  input  logic        csr_wr_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  output logic        ibus_cyc_o,
  output logic        ibus_stb_o,
  output logic [31:0] ibus_adr_o,
  input  logic [31:0] ibus_dat_i,
  input  logic        ibus_ack_i,
  output logic        inst_valid_o,
  input  logic        inst_ready_i,
  output logic [31:0] inst_pc_o,
  output logic [31:0] inst_paddr_o,
  output logic [31:0] inst_o,
  output logic        inst_uncached_o,
  output logic        inst_adef_o
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_TRANS = 2'd1;
  localparam logic [1:0] ST_BUS   = 2'd2;
  localparam logic [1:0] ST_OUT   = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       kill;
  logic       xfer;
  logic       bus_done;
  logic       discard_q;
  logic       take_fault;
  logic       take_data;

  assign kill       = redirect_i || csr_wr_i;
  assign xfer       = inst_valid_o && inst_ready_i;
  assign bus_done   = (state_q == ST_BUS) && ibus_ack_i;
  assign take_fault = (state_q == ST_TRANS) && !kill && adef_i;
  assign take_data  = bus_done && !discard_q && !kill;

  // translation only latches while idle, so paddr holds for the bus
  assign trans_en_o = state_q == ST_IDLE;
  assign ibus_adr_o = paddr_i;

  // a flush in the hand-off cycle must not refetch the word just taken
  assign pc_load_o     = kill;
  assign pc_advance_o  = xfer && !kill;
  assign pc_load_val_o = redirect_i ? redirect_pc_i : (xfer ? pc_i + 32'd4 : pc_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: state_d = kill ? ST_IDLE : ST_TRANS;
      ST_TRANS: begin
        if (kill) begin
          state_d = ST_IDLE;
        end else if (adef_i) begin
          state_d = ST_OUT;
        end else begin
          state_d = ST_BUS;
        end
      end
      ST_BUS: begin
        if (ibus_ack_i) begin
          state_d = (discard_q || kill) ? ST_IDLE : ST_OUT;
        end
      end
      ST_OUT: begin
        if (kill || xfer) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      ibus_cyc_o   <= 1'b0;
      ibus_stb_o   <= 1'b0;
      inst_valid_o <= 1'b0;
      discard_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_TRANS && !kill && !adef_i) begin
        ibus_cyc_o <= 1'b1;
        ibus_stb_o <= 1'b1;
      end else if (bus_done) begin
        ibus_cyc_o <= 1'b0;
        ibus_stb_o <= 1'b0;
      end
      // bus cycle cannot be abandoned, so remember to drop its data
      if (bus_done) begin
        discard_q <= 1'b0;
      end else if (state_q == ST_BUS && kill) begin
        discard_q <= 1'b1;
      end
      if (take_fault || take_data) begin
        inst_valid_o <= 1'b1;
      end else if (state_q == ST_OUT && (xfer || kill)) begin
        inst_valid_o <= 1'b0;
      end
    end
  end

  // output payload
  always_ff @(posedge clk) begin
    if (take_fault || take_data) begin
      inst_pc_o       <= pc_i;
      inst_paddr_o    <= paddr_i;
      inst_uncached_o <= uncached_i;
      inst_adef_o     <= take_fault;
      inst_o          <= take_fault ? 32'd0 : ibus_dat_i;
    end
  end

  stb_within_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
    ibus_stb_o |-> ibus_cyc_o);
  payload_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    inst_valid_o && !inst_ready_i && !kill |=> inst_valid_o &&
      $stable({inst_pc_o, inst_paddr_o, inst_o, inst_uncached_o, inst_adef_o}));

endmodule

// ==== source/ifetch_top.sv ====
`timescale 1ns/1ps

module ifetch_top #(
  parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
  input  logic        clk,
  input  logic        rst_n_i,
  // csr slave bus
  input  logic        csr_cyc_i,
  input  logic        csr_stb_i,
  input  logic        csr_we_i,
  input  logic [1:0]  csr_adr_i,
  input  logic [31:0] csr_dat_i,
  output logic [31:0] csr_dat_o,
  output logic        csr_ack_o,
  // instruction bus master
  output logic        ibus_cyc_o,
  output logic        ibus_stb_o,
  output logic [31:0] ibus_adr_o,
  input  logic [31:0] ibus_dat_i,
  input  logic        ibus_ack_i,
  // instruction output
  output logic        inst_valid_o,
  input  logic        inst_ready_i,
  output logic [31:0] inst_pc_o,
  output logic [31:0] inst_paddr_o,
  output logic [31:0] inst_o,
  output logic        inst_uncached_o,
  output logic        inst_adef_o,
  // redirect
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i
);

  logic                  csr_wr;
  ifetch_pkg::csr_word_u csr_crmd;
  ifetch_pkg::csr_word_u csr_dmw0;
  ifetch_pkg::csr_word_u csr_dmw1;
  logic [31:0]           pc;
  logic                  pc_advance;
  logic                  pc_load;
  logic [31:0]           pc_load_val;
  logic                  trans_en;
  logic [31:0]           paddr;
  logic                  uncached;
  logic                  adef;

  csr_regs csr_regs_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .csr_cyc_i  (csr_cyc_i),
    .csr_stb_i  (csr_stb_i),
    .csr_we_i   (csr_we_i),
    .csr_adr_i  (csr_adr_i),
    .csr_dat_i  (csr_dat_i),
    .csr_dat_o  (csr_dat_o),
    .csr_ack_o  (csr_ack_o),
    .csr_wr_o   (csr_wr),
    .csr_crmd_o (csr_crmd),
    .csr_dmw0_o (csr_dmw0),
    .csr_dmw1_o (csr_dmw1)
  );

  fetch_pc #(
    .RESET_PC (RESET_PC)
  ) fetch_pc_i (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .pc_advance_i  (pc_advance),
    .pc_load_i     (pc_load),
    .pc_load_val_i (pc_load_val),
    .pc_o          (pc)
  );

  iaddr_trans iaddr_trans_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .trans_en_i (trans_en),
    .vaddr_i    (pc),
    .csr_crmd_i (csr_crmd),
    .csr_dmw0_i (csr_dmw0),
    .csr_dmw1_i (csr_dmw1),
    .paddr_o    (paddr),
    .uncached_o (uncached),
    .adef_o     (adef)
  );

  ifetch_ctrl ifetch_ctrl_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .pc_i            (pc),
    .pc_advance_o    (pc_advance),
    .pc_load_o       (pc_load),
    .pc_load_val_o   (pc_load_val),
    .trans_en_o      (trans_en),
    .paddr_i         (paddr),
    .uncached_i      (uncached),
    .adef_i          (adef),
    .csr_wr_i        (csr_wr),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .ibus_cyc_o      (ibus_cyc_o),
    .ibus_stb_o      (ibus_stb_o),
    .ibus_adr_o      (ibus_adr_o),
    .ibus_dat_i      (ibus_dat_i),
    .ibus_ack_i      (ibus_ack_i),
    .inst_valid_o    (inst_valid_o),
    .inst_ready_i    (inst_ready_i),
    .inst_pc_o       (inst_pc_o),
    .inst_paddr_o    (inst_paddr_o),
    .inst_o          (inst_o),
    .inst_uncached_o (inst_uncached_o),
    .inst_adef_o     (inst_adef_o)
  );

endmodule

// ==== bench/ifetch_tb.sv ====
`timescale 1ns/1ps

module ifetch_tb;

  localparam logic [31:0] RESET_PC = 32'h1c00_0000;
  localparam logic [31:0] MEM_KEY  = 32'h5a5a_5a5a;
  // transfers over all phases with some margin
  localparam int N_EXPECTED = 260;

  logic        clk = 1'b0;
  logic        rst_n_i = 1'b0;
  logic        csr_cyc_i = 1'b0;
  logic        csr_stb_i = 1'b0;
  logic        csr_we_i = 1'b0;
  logic [1:0]  csr_adr_i = 2'd0;
  logic [31:0] csr_dat_i = 32'h0;
  logic [31:0] csr_dat_o;
  logic        csr_ack_o;
  logic        ibus_cyc_o;
  logic        ibus_stb_o;
  logic [31:0] ibus_adr_o;
  logic [31:0] ibus_dat_i = 32'h0;
  logic        ibus_ack_i = 1'b0;
  logic        inst_valid_o;
  logic        inst_ready_i = 1'b0;
  logic [31:0] inst_pc_o;
  logic [31:0] inst_paddr_o;
  logic [31:0] inst_o;
  logic        inst_uncached_o;
  logic        inst_adef_o;
  logic        redirect_i = 1'b0;
  logic [31:0] redirect_pc_i = 32'h0;

  integer      seed = 32'hc640;
  int          err_cnt = 0;
  int          xfer_cnt = 0;
  int          adef_cnt = 0;
  int          wait_left = -1;
  logic        bus_forbidden = 1'b0;
  logic [31:0] exp_pc = RESET_PC;

  // bench copy of the translation registers
  ifetch_pkg::csr_word_u crmd_sh = ifetch_pkg::CRMD_RESET;
  ifetch_pkg::csr_word_u dmw0_sh = '0;
  ifetch_pkg::csr_word_u dmw1_sh = '0;

  ifetch_top #(.RESET_PC (RESET_PC)) ifetch_top_i (.*);

  always #5 clk = ~clk;

  function automatic logic window_hit(input ifetch_pkg::csr_word_u w, input logic [1:0] plv,
                                      input logic [31:0] va);
    logic allowed;
    allowed = (plv == 2'd0 && w.dmw.plv0) || (plv == 2'd3 && w.dmw.plv3);
    return allowed && (w.dmw.vseg == va[31:29]);
  endfunction

  // expected {adef, uncached, paddr} for one fetch address
  function automatic logic [33:0] ref_translate(input logic [31:0] va,
      input ifetch_pkg::csr_word_u crmd, input ifetch_pkg::csr_word_u dmw0,
      input ifetch_pkg::csr_word_u dmw1);
    logic        hit0;
    logic        hit1;
    logic [31:0] pa;
    logic [1:0]  attr;
    logic        fault;
    hit0  = window_hit(dmw0, crmd.crmd.plv, va);
    hit1  = window_hit(dmw1, crmd.crmd.plv, va);
    pa    = va;
    attr  = crmd.crmd.datf;
    fault = va[1:0] != 2'b00;
    if (!crmd.crmd.da) begin
      if (hit0) begin
        pa[31:29] = dmw0.dmw.pseg;
        attr      = dmw0.dmw.mat;
      end else if (hit1) begin
        pa[31:29] = dmw1.dmw.pseg;
        attr      = dmw1.dmw.mat;
      end else begin
        fault = 1'b1;
      end
    end
    return {fault, attr != ifetch_pkg::MAT_CC, pa};
  endfunction

  // value a register holds after a write with reserved bits dropped
  function automatic logic [31:0] csr_readback(input logic [1:0] adr, input logic [31:0] dat);
    case (adr)
      ifetch_pkg::CSR_CRMD: return dat & 32'h0000_01ff;
      ifetch_pkg::CSR_DMW0, ifetch_pkg::CSR_DMW1: return dat & 32'hee00_0039;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] csr_expect(input logic [1:0] adr);
    case (adr)
      ifetch_pkg::CSR_CRMD: return crmd_sh;
      ifetch_pkg::CSR_DMW0: return dmw0_sh;
      ifetch_pkg::CSR_DMW1: return dmw1_sh;
      default: return 32'h0;
    endcase
  endfunction

  // reserved bits left set so the slave has to clear them
  function automatic logic [31:0] dmw_word(input logic [2:0] vseg, input logic [2:0] pseg,
                                           input logic [1:0] mat, input logic plv0,
                                           input logic plv3);
    ifetch_pkg::csr_word_u w;
    w          = '1;
    w.dmw.vseg = vseg;
    w.dmw.pseg = pseg;
    w.dmw.mat  = mat;
    w.dmw.plv0 = plv0;
    w.dmw.plv3 = plv3;
    return w;
  endfunction

  function automatic logic [31:0] crmd_word(input logic [1:0] plv, input logic da,
                                            input logic [1:0] datf);
    ifetch_pkg::csr_word_u w;
    w           = '1;
    w.crmd.plv  = plv;
    w.crmd.da   = da;
    w.crmd.datf = datf;
    return w;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERROR %s got %h expected %h", name, got, expected);
      err_cnt++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("ERROR %s got %h expected %h", name, got, expected);
      err_cnt++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt++;
  endtask

  task automatic csr_access(input logic we, input logic [1:0] adr, input logic [31:0] dat);
    @(posedge clk);
    csr_cyc_i <= 1'b1;
    csr_stb_i <= 1'b1;
    csr_we_i  <= we;
    csr_adr_i <= adr;
    csr_dat_i <= dat;
    do begin
      @(posedge clk);
    end while (!csr_ack_o);
    csr_cyc_i <= 1'b0;
    csr_stb_i <= 1'b0;
    csr_we_i  <= 1'b0;
    // copy changes after this edge just like the flush
    if (we) begin
      case (adr)
        ifetch_pkg::CSR_CRMD: crmd_sh <= csr_readback(adr, dat);
        ifetch_pkg::CSR_DMW0: dmw0_sh <= csr_readback(adr, dat);
        ifetch_pkg::CSR_DMW1: dmw1_sh <= csr_readback(adr, dat);
        default: ;
      endcase
    end
  endtask

  task automatic redirect_to(input logic [31:0] target);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i    <= 1'b0;
  endtask

  task automatic wait_xfers(input int n);
    int target;
    target = xfer_cnt + n;
    while (xfer_cnt < target) begin
      @(posedge clk);
    end
  endtask

  // instruction memory with random ack delay and consumer with random ready
  always @(posedge clk) begin
    inst_ready_i <= ({$random(seed)} % 4) != 0;
    if (ibus_ack_i || !rst_n_i) begin
      ibus_ack_i <= 1'b0;
    end else if (ibus_cyc_o && ibus_stb_o) begin
      if (wait_left < 0) begin
        wait_left = {$random(seed)} % 4;
      end
      if (wait_left == 0) begin
        ibus_ack_i <= 1'b1;
        ibus_dat_i <= ibus_adr_o ^ MEM_KEY;
        wait_left = -1;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  always @(posedge clk) begin : check_outputs
    logic [33:0] exp_t;
    if (rst_n_i) begin
      if (inst_valid_o && inst_ready_i) begin
        exp_t = ref_translate(exp_pc, crmd_sh, dmw0_sh, dmw1_sh);
        compare_word("inst_pc_o", inst_pc_o, exp_pc);
        compare_flag("inst_adef_o", inst_adef_o, exp_t[33]);
        if (exp_t[33]) begin
          compare_word("inst_o", inst_o, 32'h0);
          adef_cnt <= adef_cnt + 1;
        end else begin
          compare_word("inst_paddr_o", inst_paddr_o, exp_t[31:0]);
          compare_flag("inst_uncached_o", inst_uncached_o, exp_t[32]);
          compare_word("inst_o", inst_o, exp_t[31:0] ^ MEM_KEY);
        end
        exp_pc = exp_pc + 32'd4;
        xfer_cnt <= xfer_cnt + 1;
      end
      // redirect overrides the sequential stream
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
      end
      if (csr_ack_o && !csr_we_i) begin
        compare_word("csr_dat_o", csr_dat_o, csr_expect(csr_adr_i));
      end
      if (ibus_cyc_o && ibus_stb_o && bus_forbidden) begin
        note_failure("instruction bus used for a fetch that should fault");
      end
      if (ibus_cyc_o && ibus_adr_o[1:0] != 2'b00) begin
        note_failure("misaligned address on the instruction bus");
      end
    end
  end

  initial begin
    repeat (16 + 200 * N_EXPECTED) @(posedge clk);
    $display("watchdog timeout, the fetch stream stopped before the tests ended");
    $display("Errors found");
    $finish;
  end

  initial begin
    int start;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;
    // direct address mode from the reset pc
    wait_xfers(8);
    // both windows map segment 0
    csr_access(1'b1, ifetch_pkg::CSR_DMW1, dmw_word(3'd0, 3'd3, 2'd0, 1'b1, 1'b0));
    csr_access(1'b1, ifetch_pkg::CSR_DMW0, dmw_word(3'd0, 3'd1, 2'd1, 1'b1, 1'b0));
    csr_access(1'b1, ifetch_pkg::CSR_CRMD, crmd_word(2'd0, 1'b0, 2'd1));
    wait_xfers(8);
    csr_access(1'b1, ifetch_pkg::CSR_DMW0, dmw_word(3'd4, 3'd2, 2'd1, 1'b1, 1'b0));
    wait_xfers(8);
    redirect_to(32'h8000_1000);
    wait_xfers(8);
    // plv 3 against windows open to plv 0 only
    csr_access(1'b1, ifetch_pkg::CSR_CRMD, crmd_word(2'd3, 1'b0, 2'd1));
    start = adef_cnt;
    while (adef_cnt == start) begin
      @(posedge clk);
    end
    bus_forbidden <= 1'b1;
    wait_xfers(6);
    bus_forbidden <= 1'b0;
    // misaligned then aligned redirect
    csr_access(1'b1, ifetch_pkg::CSR_CRMD, crmd_word(2'd0, 1'b1, 2'd1));
    start = adef_cnt;
    redirect_to(32'h1c00_0102);
    while (adef_cnt == start) begin
      @(posedge clk);
    end
    redirect_to(32'h1c00_0400);
    wait_xfers(8);
    // long run with attributes changing under the stream
    csr_access(1'b1, ifetch_pkg::CSR_CRMD, crmd_word(2'd0, 1'b0, 2'd0));
    for (int i = 0; i < 4; i++) begin
      csr_access(1'b1, ifetch_pkg::CSR_DMW1, dmw_word(3'd0, 3'(i + 4), 2'(i), 1'b1, 1'b1));
      csr_access(1'b0, ifetch_pkg::CSR_DMW1, 32'h0);
      csr_access(1'b0, ifetch_pkg::CSR_CRMD, 32'h0);
      wait_xfers(50);
    end
    csr_access(1'b1, 2'd3, 32'hffff_ffff);
    csr_access(1'b0, 2'd3, 32'h0);
    csr_access(1'b0, ifetch_pkg::CSR_DMW0, 32'h0);
    repeat (10) @(posedge clk);
    $display("transfers %0d, adef results %0d, error count %0d", xfer_cnt, adef_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/ifetch_pkg.sv
source/csr_regs.sv
source/fetch_pc.sv
source/iaddr_trans.sv
source/ifetch_ctrl.sv
source/ifetch_top.sv
bench/ifetch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ifetch_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
